//--- list.f
+incdir+verif
verilog/isa_pkg.sv
verilog/bus_pkg.sv
verilog/alu.sv
verilog/register_file.sv
verilog/bus_master.sv
verilog/sequencer.sv
verilog/cpu_top.sv
verif/tb_cpu.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f list.f --top-module tb_cpu -o tb_cpu \
	&& ./obj_dir/tb_cpu | tee /dev/stderr | grep -q "Simulation completed successfully" \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

//--- verif/tb_ref.svh
`ifndef TB_REF_SVH
`define TB_REF_SVH

// expected result packed as data in bits 11:4, then z n h c
function automatic int ref_alu(int op, int a, int b, int f);
	int r;
	int cin;
	int z;
	int n;
	int h;
	int c;
	cin = f & 1;   // incoming carry
	n = 0;
	h = 0;
	c = 0;
	r = a;
	case (op)
	0, 1:
	begin
		if (op == 0)
			cin = 0;
		r = a + b + cin;
		h = ((a & 15) + (b & 15) + cin) > 15 ? 1 : 0;
		c = r > 255 ? 1 : 0;
	end
	2, 3, 7:
	begin
		if (op != 3)
			cin = 0;   // only sbc borrows the old carry
		r = a - b - cin;
		n = 1;
		h = ((a & 15) - (b & 15) - cin) < 0 ? 1 : 0;
		c = r < 0 ? 1 : 0;
	end
	4:
	begin
		r = a & b;
		h = 1;
	end
	5: r = a ^ b;
	6: r = a | b;
	8:
	begin
		r = b + 1;
		h = (b & 15) == 15 ? 1 : 0;
		c = f & 1;   // carry untouched
	end
	default:
	begin
		r = b - 1;
		n = 1;
		h = (b & 15) == 0 ? 1 : 0;
		c = f & 1;
	end
	endcase
	r = r & 255;
	z = (r == 0) ? 1 : 0;
	return (r << 4) | (z << 3) | (n << 2) | (h << 1) | c;
endfunction

task automatic check(input string name, input int exp, input int act);
	if (exp != act)
	begin
		$display("Error %s: expected %h, got %h", name, exp, act);
		errors++;
	end
endtask

`endif

//--- verif/tb_cpu.sv
`default_nettype none

module tb_cpu
	import isa_pkg::*, bus_pkg::*;
();

	logic clk;
	logic reset;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	flags_t flags;
	logic [7:0] mem [0:1023];
	int errors = 0;
	int seed = 32'h7c55;
	int waits = -1;
	int prog_pc = 0;
	int wr_slot = 0;      // store slots at 0x300..0x37f
	int rd_slot = 'h80;   // preloaded read bytes at 0x380..
	int model_f = 0;      // flags the program should leave
	int exp_adr [$];
	int exp_dat [$];
	int exp_flg [$];
	string exp_name [$];
	bit armed [0:1023];   // last byte of a jump
	int jtarget [0:1023];
	int jumps_expected = 0;
	int jumps_checked = 0;
	bit jump_pending = 0;
	int jump_exp;
	bit seen_first = 0;
	bit writes_done = 0;
	bit gen_done = 0;

	`include "tb_ref.svh"

	cpu_top u_cpu_top (
		.clk(clk),
		.reset(reset),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.flags(flags)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic emit(int b);
		mem[prog_pc] = b[7:0];
		prog_pc++;
	endtask

	task automatic ld_imm(int r, int v);
		emit('h06 | (r << 3));
		emit(v);
	endtask

	// ld l,slot then ld (hl),r, with h already 0x03
	task automatic store(int r, int v, string name);
		ld_imm(5, wr_slot);
		emit('h70 | r);
		exp_adr.push_back('h300 | wr_slot);
		exp_dat.push_back((r == 5) ? wr_slot : v);
		exp_flg.push_back(model_f);
		exp_name.push_back(name);
		wr_slot++;
	endtask

	task automatic arm(int target);
		armed[prog_pc - 1] = 1'b1;   // byte just emitted
		jtarget[prog_pc - 1] = target;
		jumps_expected++;
	endtask

	task automatic build_program();
		int v;
		int r2;
		int a;
		int b;
		int res;
		int vals [6];
		int jr_ops [5];
		int e;
		for (int i = 0; i < 1024; i++)
			mem[i] = 8'h00;   // nop everywhere
		ld_imm(4, 3);
		foreach (jr_ops[k])
			jr_ops[k] = 'h18 + 8 * k;   // 18, 20 nz, 28 z, 30 nc, 38 c
		for (int r = 0; r < 8; r++)
		begin
			if (r == 4 || r == 5 || r == 6)
				continue;
			v = $random(seed) & 255;
			ld_imm(r, v);
			store(r, v, $sformatf("ld r%0d,d8", r));
			r2 = (r == 7) ? 0 : (r == 3) ? 7 : r + 1;   // h and l stay the store pointer
			emit('h40 | (r2 << 3) | r);
			store(r2, v, $sformatf("ld r%0d,r%0d", r2, r));
		end
		store(4, 3, "ld (hl),h");
		store(5, 0, "ld (hl),l");
		emit('h44);   // ld b,h
		store(0, 3, "ld b,h");
		// alu, modes register, immediate, (hl)
		for (int op = 0; op < 8; op++)
			for (int mode = 0; mode < 3; mode++)
			begin
				a = $random(seed) & 255;
				b = $random(seed) & 255;
				ld_imm(7, a);
				if (mode == 0)
				begin
					ld_imm(0, b);
					emit('h80 | (op << 3));
				end
				else if (mode == 1)
				begin
					emit('hc6 | (op << 3));
					emit(b);
				end
				else
				begin
					mem['h300 | rd_slot] = b[7:0];
					ld_imm(5, rd_slot);
					rd_slot++;
					emit('h86 | (op << 3));
				end
				res = ref_alu(op, a, b, model_f);
				model_f = res & 15;
				if (op != 7)
					a = res >> 4;   // cp keeps a
				store(7, a, $sformatf("alu op%0d mode%0d", op, mode));
			end
		vals = '{'h00, 'h0f, 'h10, 'hff, 0, 0};
		vals[4] = $random(seed) & 255;
		vals[5] = $random(seed) & 255;
		for (int i = 0; i < 6; i++)
			for (int dec = 0; dec < 2; dec++)
			begin
				a = (i == 0) ? 'hff : $random(seed) & 255;
				b = (i == 0) ? 1 : $random(seed) & 255;   // first pass forces c
				ld_imm(7, a);
				emit('hc6);
				emit(b);
				model_f = ref_alu(0, a, b, model_f) & 15;
				ld_imm(1, vals[i]);
				emit(dec ? 'h0d : 'h0c);
				res = ref_alu(8 + dec, 0, vals[i], model_f);
				model_f = res & 15;
				store(1, res >> 4, $sformatf("%s %h", dec ? "dec" : "inc", vals[i]));
			end
		for (int r = 0; r < 4; r++)
		begin
			v = $random(seed) & 255;
			mem['h300 | rd_slot] = v[7:0];
			ld_imm(5, rd_slot);
			rd_slot++;
			emit('h46 | (r << 3));
			store(r, v, $sformatf("ld r%0d,(hl)", r));
		end
		// jp a16 over three nops
		emit('hc3);
		emit((prog_pc + 5) & 255);
		emit((prog_pc + 4) >> 8);
		arm(prog_pc + 3);
		prog_pc += 3;
		for (int k = 0; k < 5; k++)
			for (int eq = 0; eq < 2; eq++)
			begin
				a = $random(seed) & 127;
				b = eq ? a : a + 1 + ($random(seed) & 63);
				ld_imm(7, a);
				emit('hfe);   // cp d8
				emit(b);
				model_f = ref_alu(7, a, b, model_f) & 15;
				e = 1 + ($random(seed) & 3);
				emit(jr_ops[k]);
				emit(e);
				case (k)
				0: v = 1;
				1: v = !model_f[3];
				2: v = model_f[3];
				3: v = !model_f[0];
				default: v = model_f[0];
				endcase
				arm(v ? prog_pc + e : prog_pc);
				prog_pc += e;
			end
		// forward past the middle jr, back to it, then out
		emit('h18);
		emit(2);
		arm(prog_pc + 2);
		emit('h18);
		emit(2);
		arm(prog_pc + 2);
		emit('h18);
		emit('hfc);   // offset -4
		arm(prog_pc - 4);
		store(7, a, "after jumps");
		emit('h18);
		emit('hfe);   // spin in place
		if (prog_pc >= 'h300)
		begin
			$display("Generated program runs into the data area");
			errors++;
		end
	endtask

	// slave with 0 to 3 wait states
	always @(posedge clk)
	begin
		#10;
		if (reset || wb_rsp.ack)
		begin
			wb_rsp.ack = 1'b0;
			waits = -1;
		end
		else if (wb_req.stb)
		begin
			if (waits < 0)
				waits = $random(seed) & 3;
			if (waits == 0)
			begin
				if (wb_req.we)
					mem[wb_req.adr[9:0]] = wb_req.dat_o;
				else
					wb_rsp.dat_i = mem[wb_req.adr[9:0]];
				wb_rsp.ack = 1'b1;
				waits = -1;
			end
			else
				waits--;
		end
	end

	// compare on every acknowledged transfer
	always @(posedge clk)
	begin
		if (!reset && wb_rsp.ack && wb_req.stb)
		begin
			if (!seen_first)
			begin
				check("first fetch adr", 0, int'(wb_req.adr));
				check("first fetch we", 0, int'(wb_req.we));
				check("reset flags", 0, int'(flags));
				seen_first = 1;
			end
			if (wb_req.we)
			begin
				if (exp_adr.size() == 0)
				begin
					$display("Unexpected write to address %h", wb_req.adr);
					errors++;
				end
				else
				begin
					check({exp_name[0], " adr"}, exp_adr.pop_front(), int'(wb_req.adr));
					check({exp_name[0], " data"}, exp_dat.pop_front(), int'(wb_req.dat_o));
					check({exp_name[0], " flags"}, exp_flg.pop_front(), int'(flags));
					void'(exp_name.pop_front());
					if (exp_adr.size() == 0)
						writes_done = 1;
				end
			end
			else
			begin
				if (jump_pending)
				begin
					check("fetch after jump", jump_exp, int'(wb_req.adr));
					jump_pending = 0;
					jumps_checked++;
				end
				if (armed[wb_req.adr[9:0]])
				begin
					armed[wb_req.adr[9:0]] = 1'b0;
					jump_exp = jtarget[wb_req.adr[9:0]];
					jump_pending = 1;
				end
			end
		end
	end

	// budget of two transfers per byte, eight cycles each
	initial
	begin
		wait (gen_done);
		#(prog_pc * 2 * 8 * 100 + 5000);
		$display("Timeout, the program did not finish in time");
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		reset = 1'b1;
		wb_rsp.ack = 1'b0;
		wb_rsp.dat_i = 8'h00;
		build_program();
		gen_done = 1;
		repeat (4)
		begin
			@(posedge clk);
			#10;
			check("reset cyc", 0, int'(wb_req.cyc));
			check("reset stb", 0, int'(wb_req.stb));
			check("reset we", 0, int'(wb_req.we));
		end
		reset = 1'b0;
		wait (writes_done);
		repeat (2) @(posedge clk);
		if (jumps_checked != jumps_expected)
		begin
			$display("Only %0d of %0d jumps were checked", jumps_checked, jumps_expected);
			errors++;
		end
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/alu.sv
`default_nettype none

module alu
	import isa_pkg::*;
(
	input wire alu_op_t op,
	input wire byte_t acc,
	input wire byte_t opnd,
	input wire flags_t flags_in,
	output alu_res_t res
);

	logic cin;         // carry or borrow in
	logic [4:0] nib;   // low nibble result, bit 4 is half carry
	logic [8:0] full;  // byte result, bit 8 is carry

	// only the with-carry forms look at c
	assign cin = flags_in.c & (op == ALU_ADC || op == ALU_SBC);

	always_comb
	begin
		nib = '0;
		full = '0;
		res.flags.n = 1'b0;
		res.flags.h = 1'b0;
		res.flags.c = 1'b0;
		case (op)
		ALU_ADD, ALU_ADC:
		begin
			nib = {1'b0, acc[3:0]} + {1'b0, opnd[3:0]} + 5'(cin);
			full = {1'b0, acc} + {1'b0, opnd} + 9'(cin);
			res.flags.h = nib[4];   // carry out of bit 3
			res.flags.c = full[8];  // carry out of bit 7
		end
		ALU_SUB, ALU_SBC, ALU_CP:
		begin
			nib = {1'b0, acc[3:0]} - {1'b0, opnd[3:0]} - 5'(cin);
			full = {1'b0, acc} - {1'b0, opnd} - 9'(cin);
			res.flags.n = 1'b1;
			res.flags.h = nib[4];   // borrow from bit 4
			res.flags.c = full[8];  // borrow from bit 8
		end
		ALU_AND:
		begin
			full = {1'b0, acc & opnd};
			res.flags.h = 1'b1;
		end
		ALU_XOR:
			full = {1'b0, acc ^ opnd};
		ALU_OR:
			full = {1'b0, acc | opnd};
		ALU_INC:
		begin
			// works on the operand, acc unused
			nib = {1'b0, opnd[3:0]} + 5'd1;
			full = {1'b0, opnd} + 9'd1;
			res.flags.h = nib[4];
			res.flags.c = flags_in.c;
		end
		ALU_DEC:
		begin
			nib = {1'b0, opnd[3:0]} - 5'd1;
			full = {1'b0, opnd} - 9'd1;
			res.flags.n = 1'b1;
			res.flags.h = nib[4];
			res.flags.c = flags_in.c;
		end
		default:
			full = {1'b0, acc};  // unused codes pass a through
		endcase
		res.data = full[7:0];  // cp still returns the difference
		res.flags.z = (full[7:0] == 8'h00);
	end

endmodule

`default_nettype wire

//--- verilog/bus_master.sv
`default_nettype none

module bus_master
	import bus_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire mem_req_t req,
	output mem_rsp_t rsp,
	output wb_req_t wb_req,
	input wire wb_rsp_t wb_rsp
);

	typedef enum logic {idle, busy} bm_state_t;

	bm_state_t state;
	logic active;       // cyc and stb, always together
	logic we_q;
	wb_addr_t adr_q;
	wb_data_t dat_q;
	logic done_q;
	wb_data_t rdata_q;

	assign wb_req.cyc = active;
	assign wb_req.stb = active;
	assign wb_req.we = we_q;
	assign wb_req.adr = adr_q;
	assign wb_req.dat_o = dat_q;
	assign rsp.done = done_q;
	assign rsp.rdata = rdata_q;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= idle;
			active <= 1'b0;
			we_q <= 1'b0;
			done_q <= 1'b0;
		end
		else
		begin
			done_q <= 1'b0;  // single cycle pulse
			case (state)
			idle:
				if (req.valid)
				begin
					active <= 1'b1;
					we_q <= req.we;
					state <= busy;
				end
			busy:
				if (wb_rsp.ack)
				begin
					active <= 1'b0;  // drop on the clock after ack
					we_q <= 1'b0;
					done_q <= 1'b1;
					state <= idle;
				end
			default:
				state <= idle;
			endcase
		end
	end

	// address, data and read byte capture
	always_ff @(posedge clk)
	begin
		if (state == idle && req.valid)
		begin
			adr_q <= req.adr;
			dat_q <= req.wdata;
		end
		if (state == busy && wb_rsp.ack)
			rdata_q <= wb_rsp.dat_i;
	end

	assert property (@(posedge clk) disable iff (reset)
		wb_req.stb |-> wb_req.cyc);

	// slave may stretch the cycle, request must not move
	assert property (@(posedge clk) disable iff (reset)
		wb_req.stb && !wb_rsp.ack |=> $stable(wb_req.adr) && $stable(wb_req.we)
			&& $stable(wb_req.dat_o));

endmodule

`default_nettype wire

//--- verilog/bus_pkg.sv
`default_nettype none

package bus_pkg;

	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	typedef logic [ADDR_W-1:0] wb_addr_t;
	typedef logic [DATA_W-1:0] wb_data_t;

	// wishbone classic, master side
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		wb_addr_t adr;
		wb_data_t dat_o;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		wb_data_t dat_i;
	} wb_rsp_t;

	// core side, held until done
	typedef struct packed {
		logic valid;
		logic we;
		wb_addr_t adr;
		wb_data_t wdata;
	} mem_req_t;

	typedef struct packed {
		logic done;       // one cycle pulse
		wb_data_t rdata;  // valid with done
	} mem_rsp_t;

endpackage

`default_nettype wire

//--- verilog/cpu_top.sv
`default_nettype none

module cpu_top
	import isa_pkg::*, bus_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	output wb_req_t wb_req,
	input wire wb_rsp_t wb_rsp,
	output flags_t flags
);

	mem_req_t mem_req;
	mem_rsp_t mem_rsp;
	reg_code_t src;
	reg_code_t dst;
	byte_t src_val;
	byte_t dst_val;
	byte_t a_val;      // accumulator, shared by sequencer and alu
	word_t hl;
	reg_wr_t reg_wr;
	flags_wr_t flags_wr;
	alu_op_t alu_op;
	byte_t alu_opnd;
	alu_res_t alu_res;

	sequencer u_sequencer (
		.clk(clk),
		.reset(reset),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp),
		.src(src),
		.dst(dst),
		.src_val(src_val),
		.dst_val(dst_val),
		.a_val(a_val),
		.hl(hl),
		.reg_wr(reg_wr),
		.flags_wr(flags_wr),
		.flags(flags),
		.alu_op(alu_op),
		.alu_opnd(alu_opnd),
		.alu_res(alu_res)
	);

	register_file u_register_file (
		.clk(clk),
		.reset(reset),
		.src(src),
		.dst(dst),
		.src_val(src_val),
		.dst_val(dst_val),
		.a_val(a_val),
		.hl(hl),
		.wr(reg_wr),
		.flags_wr(flags_wr),
		.flags(flags)  // also brought out
	);

	alu u_alu (
		.op(alu_op),
		.acc(a_val),
		.opnd(alu_opnd),
		.flags_in(flags),
		.res(alu_res)
	);

	bus_master u_bus_master (
		.clk(clk),
		.reset(reset),
		.req(mem_req),
		.rsp(mem_rsp),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp)
	);

endmodule

`default_nettype wire

//--- verilog/isa_pkg.sv
`default_nettype none

package isa_pkg;

	typedef logic [7:0] byte_t;   // data byte
	typedef logic [15:0] word_t;  // register pair or program address

	// register field of an opcode, B C D E H L (HL) A
	typedef logic [2:0] reg_code_t;

	localparam reg_code_t REG_MEM_HL = 3'd6;  // memory at HL, no storage behind it
	localparam reg_code_t REG_A = 3'd7;

	// first eight follow opcode bits 5:3 of the accumulator group
	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_ADC = 4'd1,
		ALU_SUB = 4'd2,
		ALU_SBC = 4'd3,
		ALU_AND = 4'd4,
		ALU_XOR = 4'd5,
		ALU_OR  = 4'd6,
		ALU_CP  = 4'd7,
		ALU_INC = 4'd8,
		ALU_DEC = 4'd9
	} alu_op_t;

	typedef struct packed {
		logic z;  // zero
		logic n;  // subtract
		logic h;  // half carry
		logic c;  // carry
	} flags_t;

	typedef struct packed {
		byte_t data;
		flags_t flags;
	} alu_res_t;

	typedef struct packed {
		logic en;
		reg_code_t code;
		byte_t data;
	} reg_wr_t;

	typedef struct packed {
		logic en;
		logic keep_c;  // inc and dec leave carry alone
		flags_t flags;
	} flags_wr_t;

	localparam byte_t OP_NOP = 8'h00;
	localparam byte_t OP_JP = 8'hc3;  // jp a16
	localparam byte_t OP_JR = 8'h18;  // unconditional jr e8

	// immediate forms all end in 110, masked with OP_LD_IMM_MASK
	localparam byte_t OP_ALU_IMM_BASE = 8'hc6;  // 11ooo110, alu a,d8
	localparam byte_t OP_LD_IMM_MASK = 8'hc7;   // 00rrr110 after masking is ld r,d8

endpackage

`default_nettype wire

//--- verilog/register_file.sv
`default_nettype none

module register_file
	import isa_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire reg_code_t src,
	input wire reg_code_t dst,
	output byte_t src_val,
	output byte_t dst_val,
	output byte_t a_val,
	output word_t hl,
	input wire reg_wr_t wr,
	input wire flags_wr_t flags_wr,
	output flags_t flags
);

	byte_t regs [0:6];  // b c d e h l, then a

	// a sits in the slot (HL) would take
	function automatic reg_code_t slot(reg_code_t code);
		return (code == REG_A) ? REG_MEM_HL : code;
	endfunction

	// (HL) code has no storage, reads as zero
	assign src_val = (src == REG_MEM_HL) ? 8'h00 : regs[slot(src)];
	assign dst_val = (dst == REG_MEM_HL) ? 8'h00 : regs[slot(dst)];
	assign a_val = regs[slot(REG_A)];
	assign hl = {regs[4], regs[5]};  // h high, l low

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 7; i++)
				regs[i] <= 8'h00;
			flags <= '0;
		end
		else
		begin
			if (wr.en && wr.code != REG_MEM_HL)
				regs[slot(wr.code)] <= wr.data;
			if (flags_wr.en)
			begin
				flags.z <= flags_wr.flags.z;
				flags.n <= flags_wr.flags.n;
				flags.h <= flags_wr.flags.h;
				flags.c <= flags_wr.keep_c ? flags.c : flags_wr.flags.c;  // inc/dec keep c
			end
		end
	end

	// sequencer must not write with an undecoded opcode
	assert property (@(posedge clk) disable iff (reset)
		wr.en |-> !$isunknown(wr.code));

endmodule

`default_nettype wire

//--- verilog/sequencer.sv
`default_nettype none

module sequencer
	import isa_pkg::*, bus_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	output mem_req_t mem_req,
	input wire mem_rsp_t mem_rsp,
	output reg_code_t src,
	output reg_code_t dst,
	input wire byte_t src_val,
	input wire byte_t dst_val,
	input wire byte_t a_val,
	input wire word_t hl,
	output reg_wr_t reg_wr,
	output flags_wr_t flags_wr,
	input wire flags_t flags,
	output alu_op_t alu_op,
	output byte_t alu_opnd,
	input wire alu_res_t alu_res
);

	typedef enum logic [2:0] {
		fetch_op,
		fetch_imml,
		fetch_immh,
		mem_read,
		mem_write,
		exec
	} seq_state_t;

	seq_state_t state;
	seq_state_t state_nxt;
	word_t pc;
	byte_t op_q;    // opcode of the running instruction
	byte_t imml;    // low immediate, also the byte read from (HL)
	byte_t immh;
	byte_t cur_op;  // opcode being decoded
	byte_t opnd;    // load value or alu operand
	logic in_fetch;
	logic is_ld_rr;
	logic is_ld_imm;
	logic is_alu_imm;
	logic is_alu;
	logic is_incdec;
	logic is_jp;
	logic is_jr;
	logic need_imm;
	logic need_read;
	logic need_write;
	logic jr_taken;

	// decode straight off the bus while the opcode lands
	assign cur_op = (state == fetch_op) ? mem_rsp.rdata : op_q;
	assign src = cur_op[2:0];
	assign dst = cur_op[5:3];

	assign is_ld_rr = cur_op[7:6] == 2'b01 && !(src == REG_MEM_HL && dst == REG_MEM_HL);
	assign is_ld_imm = (cur_op & OP_LD_IMM_MASK) == 8'h06 && dst != REG_MEM_HL;
	assign is_alu_imm = (cur_op & OP_LD_IMM_MASK) == OP_ALU_IMM_BASE;
	assign is_alu = cur_op[7:6] == 2'b10 || is_alu_imm;
	assign is_incdec = cur_op[7:6] == 2'b00 && cur_op[2:1] == 2'b10 && dst != REG_MEM_HL;
	assign is_jp = cur_op == OP_JP;
	assign is_jr = cur_op == OP_JR || (cur_op & 8'he7) == 8'h20;  // jr, jr nz/z/nc/c

	assign need_imm = is_ld_imm || is_alu_imm || is_jp || is_jr;
	assign need_read = (is_ld_rr || is_alu) && !is_alu_imm && src == REG_MEM_HL;
	assign need_write = is_ld_rr && dst == REG_MEM_HL;

	// bit 4 picks c or z, bit 3 the wanted value
	assign jr_taken = is_jr && (cur_op == OP_JR || (cur_op[4] ? flags.c : flags.z) == cur_op[3]);

	// every immediate or (HL) form has 110 in the source field
	assign opnd = (src == REG_MEM_HL) ? imml : src_val;

	assign alu_op = is_incdec ? (cur_op[0] ? ALU_DEC : ALU_INC) : alu_op_t'({1'b0, cur_op[5:3]});
	assign alu_opnd = is_incdec ? dst_val : opnd;

	// request held until done, dropped in the done cycle
	assign in_fetch = state == fetch_op || state == fetch_imml || state == fetch_immh;
	assign mem_req.valid = (in_fetch || state == mem_read || state == mem_write) && !mem_rsp.done;
	assign mem_req.we = state == mem_write;
	assign mem_req.adr = in_fetch ? pc : hl;
	assign mem_req.wdata = src_val;  // ld (hl),r

	always_comb
	begin
		state_nxt = state;
		case (state)
		fetch_op:
			if (mem_rsp.done)
			begin
				if (need_imm)
					state_nxt = fetch_imml;
				else if (need_write)
					state_nxt = mem_write;
				else if (need_read)
					state_nxt = mem_read;
				else
					state_nxt = exec;  // register ops and nop
			end
		fetch_imml:
			if (mem_rsp.done)
				state_nxt = is_jp ? fetch_immh : exec;
		fetch_immh, mem_read:
			if (mem_rsp.done)
				state_nxt = exec;
		mem_write:
			if (mem_rsp.done)
				state_nxt = fetch_op;  // store has no writeback
		default:
			state_nxt = fetch_op;
		endcase
	end

	// writebacks land at the end of exec
	always_comb
	begin
		reg_wr.en = 1'b0;
		reg_wr.code = dst;
		reg_wr.data = opnd;
		flags_wr.en = 1'b0;
		flags_wr.keep_c = 1'b0;
		flags_wr.flags = alu_res.flags;
		if (state == exec)
		begin
			if (is_ld_rr || is_ld_imm)
				reg_wr.en = 1'b1;
			else if (is_alu)
			begin
				reg_wr.en = 1'b1;
				reg_wr.code = REG_A;
				reg_wr.data = (alu_op == ALU_CP) ? a_val : alu_res.data;  // cp rewrites a as is
				flags_wr.en = 1'b1;
			end
			else if (is_incdec)
			begin
				reg_wr.en = 1'b1;
				reg_wr.data = alu_res.data;
				flags_wr.en = 1'b1;
				flags_wr.keep_c = 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= fetch_op;
			pc <= 16'h0000;
			op_q <= OP_NOP;
		end
		else
		begin
			state <= state_nxt;
			if (state == fetch_op && mem_rsp.done)
				op_q <= mem_rsp.rdata;
			if (in_fetch && mem_rsp.done)
				pc <= pc + 16'd1;
			else if (state == exec && is_jp)
				pc <= {immh, imml};
			else if (state == exec && jr_taken)
				pc <= pc + {{8{imml[7]}}, imml};  // pc already past the offset
		end
	end

	always_ff @(posedge clk)
	begin
		if (mem_rsp.done && (state == fetch_imml || state == mem_read))
			imml <= mem_rsp.rdata;
		if (mem_rsp.done && state == fetch_immh)
			immh <= mem_rsp.rdata;
	end

	assert property (@(posedge clk) disable iff (reset)
		state inside {fetch_op, fetch_imml, fetch_immh, mem_read, mem_write, exec});

	// (HL) goes over the bus, never into the register file
	assert property (@(posedge clk) disable iff (reset)
		reg_wr.en |-> reg_wr.code != REG_MEM_HL);

endmodule

`default_nettype wire
